// ==== hdl/rgmii_pkg.sv ====
package rgmii_pkg;

	//////////////////////////////////////////////////////////////////////
	// Link speed

	// Same order as bits 2:1 of the in-band status byte
	typedef enum logic [1:0] {
		SPEED_10   = 2'b00,
		SPEED_100  = 2'b01,
		SPEED_1000 = 2'b10,
		SPEED_RSVD = 2'b11
	} gmii_speed_t;

	//////////////////////////////////////////////////////////////////////
	// Receive framer

	// Walk from the gap through the preamble into the payload
	typedef enum logic [1:0] {
		// Waiting for enable to rise
		FR_IDLE     = 2'b00,
		// Inside the preamble, looking for the delimiter
		FR_PREAMBLE = 2'b01,
		// Payload bytes go out through the holding register
		FR_PAYLOAD  = 2'b10,
		// Bad or overlong frame, wait for enable to fall
		FR_DROP     = 2'b11
	} framer_state_t;

	//////////////////////////////////////////////////////////////////////
	// Ethernet preamble

	// Repeated preamble byte ahead of the delimiter
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	// Start-of-frame delimiter
	localparam logic [7:0] SFD_BYTE      = 8'hD5;

endpackage

// ==== hdl/rgmii_rx_ddr.sv ====
`timescale 1ns/1ps

module rgmii_rx_ddr (
	input  logic       gmii_rxc,
	input  logic       rst,
	// RGMII receive pins from the PHY
	input  logic [3:0] rgmii_rxd,
	input  logic       rgmii_rx_ctl,
	// Rebuilt GMII byte stream
	output logic [7:0] gmii_rx_data,
	output logic       gmii_rx_en,
	output logic       gmii_rx_er,
	output logic       gmii_rx_status_ok
);

	//////////////////////////////////////////////////////////////////////
	// Falling-edge half

	// Low nibble and RX_DV half, launched after the rising edge
	logic [3:0] rxd_fall;
	logic       ctl_fall;

	always_ff @(negedge gmii_rxc) begin
		rxd_fall <= rgmii_rxd;
		ctl_fall <= rgmii_rx_ctl;
	end

	//////////////////////////////////////////////////////////////////////
	// Control decode

	// First control half is the data valid flag
	logic rx_dv;
	// Second half carries DV xor ER to keep the line quiet
	logic rx_err_half;
	// Both halves low marks an idle byte with in-band status
	logic rx_idle;

	assign rx_dv       = ctl_fall;
	assign rx_err_half = ctl_fall ^ rgmii_rx_ctl;
	assign rx_idle     = ~ctl_fall & ~rgmii_rx_ctl;

	//////////////////////////////////////////////////////////////////////
	// Rising-edge byte register

	always_ff @(posedge gmii_rxc) begin
		// High nibble is on the pins now, low nibble came half a cycle back
		gmii_rx_data <= {rgmii_rxd, rxd_fall};
		if (rst) begin
			gmii_rx_en        <= 1'b0;
			gmii_rx_er        <= 1'b0;
			gmii_rx_status_ok <= 1'b0;
		end else begin
			gmii_rx_en        <= rx_dv;
			// Error with DV low is a carrier symbol, not a frame error
			gmii_rx_er        <= rx_dv & rx_err_half;
			gmii_rx_status_ok <= rx_idle;
		end
	end

endmodule

// ==== hdl/rgmii_inband_status.sv ====
`timescale 1ns/1ps

module rgmii_inband_status import rgmii_pkg::*; (
	input  logic        gmii_rxc,
	input  logic        rst,
	// Byte stream from the DDR capture
	input  logic [7:0]  gmii_rx_data,
	input  logic        gmii_rx_status_ok,
	// Last status seen in the inter-frame gap
	output logic        link_up,
	output gmii_speed_t link_speed,
	output logic        full_duplex
);

	//////////////////////////////////////////////////////////////////////
	// Status byte fields

	// Bit 0 is link state
	logic        stat_link;
	// Bits 2:1 give the clock rate
	gmii_speed_t stat_speed;
	// Bit 3 is duplex mode
	logic        stat_duplex;

	assign stat_link   = gmii_rx_data[0];
	assign stat_speed  = gmii_speed_t'(gmii_rx_data[2:1]);
	assign stat_duplex = gmii_rx_data[3];

	// Bits 7:4 mirror the low nibble on most PHYs and are ignored

	//////////////////////////////////////////////////////////////////////
	// Status registers

	always_ff @(posedge gmii_rxc) begin
		if (rst) begin
			link_up     <= 1'b0;
			link_speed  <= SPEED_10;
			full_duplex <= 1'b0;
		end else if (gmii_rx_status_ok) begin
			// Only plain idle bytes update the status
			// Frame data and carrier symbols leave it alone
			link_up     <= stat_link;
			link_speed  <= stat_speed;
			full_duplex <= stat_duplex;
		end
	end

	// Speed is reported only
	// The datapath always runs at the single gigabit clock

endmodule

// ==== hdl/gmii_rx_framer.sv ====
`timescale 1ns/1ps

module gmii_rx_framer import rgmii_pkg::*; #(
	parameter logic [15:0] MAX_FRAME_LEN = 16'd1518,
	parameter int          LEN_WIDTH     = 16
) (
	input  logic                 gmii_rxc,
	input  logic                 rst,
	// GMII receive stream
	input  logic [7:0]           gmii_rx_data,
	input  logic                 gmii_rx_en,
	input  logic                 gmii_rx_er,
	// Payload bytes with frame strobes
	output logic [7:0]           rx_data,
	output logic                 rx_valid,
	output logic                 rx_sof,
	output logic                 rx_eof,
	output logic                 rx_err,
	output logic [LEN_WIDTH-1:0] rx_len
);

	// Payload limit at the width of the counter
	localparam logic [LEN_WIDTH-1:0] MAX_LEN = LEN_WIDTH'(MAX_FRAME_LEN);

	framer_state_t state;

	// One byte of lookahead so the end strobe lands on the last byte
	logic [7:0]           hold_data;
	logic                 hold_valid;
	// Sticky error over the payload
	logic                 err_seen;
	// Bytes already sent in this frame
	logic [LEN_WIDTH-1:0] out_count;
	logic [LEN_WIDTH-1:0] count_inc;
	// Held byte is the last one the limit allows
	logic                 at_limit;

	assign count_inc = out_count + 1'b1;
	assign at_limit  = hold_valid && (count_inc == MAX_LEN);

	//////////////////////////////////////////////////////////////////////
	// Framer FSM

	always_ff @(posedge gmii_rxc) begin
		// Strobes last one cycle
		rx_valid <= 1'b0;
		rx_sof   <= 1'b0;
		rx_eof   <= 1'b0;
		rx_err   <= 1'b0;
		if (rst) begin
			state      <= FR_IDLE;
			hold_valid <= 1'b0;
			err_seen   <= 1'b0;
			out_count  <= '0;
		end else begin
			case (state)
				FR_IDLE: begin
					if (gmii_rx_en) begin
						// Frame has to open with a preamble byte
						if (gmii_rx_er || gmii_rx_data != PREAMBLE_BYTE)
							state <= FR_DROP;
						else
							state <= FR_PREAMBLE;
					end
				end

				FR_PREAMBLE: begin
					if (!gmii_rx_en) begin
						// Ended in the preamble, nothing to report
						state <= FR_IDLE;
					end else if (gmii_rx_er) begin
						state <= FR_DROP;
					end else if (gmii_rx_data == SFD_BYTE) begin
						// Delimiter found, start a fresh frame
						state      <= FR_PAYLOAD;
						hold_valid <= 1'b0;
						err_seen   <= 1'b0;
						out_count  <= '0;
					end else if (gmii_rx_data != PREAMBLE_BYTE) begin
						state <= FR_DROP;
					end
				end

				FR_PAYLOAD: begin
					// Held byte goes out once we know what follows it
					if (hold_valid) begin
						rx_valid  <= 1'b1;
						rx_data   <= hold_data;
						rx_sof    <= (out_count == '0);
						rx_len    <= count_inc;
						out_count <= count_inc;
					end
					if (!gmii_rx_en) begin
						// Enable fell so the held byte was the last
						// Empty payload sends nothing
						rx_eof     <= hold_valid;
						rx_err     <= hold_valid & err_seen;
						hold_valid <= 1'b0;
						state      <= FR_IDLE;
					end else if (at_limit) begin
						// Too long, close here and drop the rest
						rx_eof     <= 1'b1;
						rx_err     <= 1'b1;
						hold_valid <= 1'b0;
						state      <= FR_DROP;
					end else begin
						hold_data  <= gmii_rx_data;
						hold_valid <= 1'b1;
						if (gmii_rx_er)
							err_seen <= 1'b1;
					end
				end

				FR_DROP: begin
					// Discard until the gap
					if (!gmii_rx_en)
						state <= FR_IDLE;
				end

				default: state <= FR_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/rgmii_tx_ddr.sv ====
`timescale 1ns/1ps

module rgmii_tx_ddr (
	input  logic       gmii_rxc,
	input  logic       rst,
	// GMII transmit byte from the MAC
	input  logic [7:0] tx_data,
	input  logic       tx_en,
	input  logic       tx_er,
	// RGMII transmit pins to the PHY
	output logic       rgmii_txc,
	output logic [3:0] rgmii_txd,
	output logic       rgmii_tx_ctl
);

	//////////////////////////////////////////////////////////////////////
	// Rising-edge capture

	logic [7:0] txd_rise;
	// TX_EN for the high clock phase
	logic       ctl_first;
	// EN xor ER for the low clock phase
	logic       ctl_second;

	always_ff @(posedge gmii_rxc) begin
		if (rst) begin
			txd_rise   <= '0;
			ctl_first  <= 1'b0;
			ctl_second <= 1'b0;
		end else begin
			txd_rise   <= tx_data;
			ctl_first  <= tx_en;
			ctl_second <= tx_en ^ tx_er;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Falling-edge half

	// Second half of the byte, held for the low phase
	logic [3:0] txd_fall;
	logic       ctl_fall;

	always_ff @(negedge gmii_rxc) begin
		if (rst) begin
			txd_fall <= '0;
			ctl_fall <= 1'b0;
		end else begin
			txd_fall <= txd_rise[7:4];
			ctl_fall <= ctl_second;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output mux and forwarded clock

	// Clock phase picks the half, as an output DDR register would
	assign rgmii_txd    = gmii_rxc ? txd_rise[3:0] : txd_fall;
	assign rgmii_tx_ctl = gmii_rxc ? ctl_first : ctl_fall;
	assign rgmii_txc    = gmii_rxc;

endmodule

// ==== hdl/rgmii_phy_if.sv ====
`timescale 1ns/1ps

module rgmii_phy_if import rgmii_pkg::*; #(
	parameter logic [15:0] MAX_FRAME_LEN = 16'd1518,
	parameter int          LEN_WIDTH     = 16
) (
	input  logic                 gmii_rxc,
	input  logic                 rst,
	// RGMII receive pins
	input  logic [3:0]           rgmii_rxd,
	input  logic                 rgmii_rx_ctl,
	// GMII transmit side from the MAC
	input  logic [7:0]           tx_data,
	input  logic                 tx_en,
	input  logic                 tx_er,
	// RGMII transmit pins
	output logic                 rgmii_txc,
	output logic [3:0]           rgmii_txd,
	output logic                 rgmii_tx_ctl,
	// Framed receive payload
	output logic [7:0]           rx_data,
	output logic                 rx_valid,
	output logic                 rx_sof,
	output logic                 rx_eof,
	output logic                 rx_err,
	output logic [LEN_WIDTH-1:0] rx_len,
	// In-band link status
	output logic                 link_up,
	output gmii_speed_t          link_speed,
	output logic                 full_duplex
);

	//////////////////////////////////////////////////////////////////////
	// Receive chain

	// GMII byte stream shared by framer and status decoder
	logic [7:0] gmii_rx_data;
	logic       gmii_rx_en;
	logic       gmii_rx_er;
	logic       gmii_rx_status_ok;

	rgmii_rx_ddr i_rgmii_rx_ddr (
		.gmii_rxc          (gmii_rxc),
		.rst               (rst),
		.rgmii_rxd         (rgmii_rxd),
		.rgmii_rx_ctl      (rgmii_rx_ctl),
		.gmii_rx_data      (gmii_rx_data),
		.gmii_rx_en        (gmii_rx_en),
		.gmii_rx_er        (gmii_rx_er),
		.gmii_rx_status_ok (gmii_rx_status_ok)
	);

	rgmii_inband_status i_rgmii_inband_status (
		.gmii_rxc          (gmii_rxc),
		.rst               (rst),
		.gmii_rx_data      (gmii_rx_data),
		.gmii_rx_status_ok (gmii_rx_status_ok),
		.link_up           (link_up),
		.link_speed        (link_speed),
		.full_duplex       (full_duplex)
	);

	gmii_rx_framer #(
		.MAX_FRAME_LEN (MAX_FRAME_LEN),
		.LEN_WIDTH     (LEN_WIDTH)
	) i_gmii_rx_framer (
		.gmii_rxc     (gmii_rxc),
		.rst          (rst),
		.gmii_rx_data (gmii_rx_data),
		.gmii_rx_en   (gmii_rx_en),
		.gmii_rx_er   (gmii_rx_er),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_sof       (rx_sof),
		.rx_eof       (rx_eof),
		.rx_err       (rx_err),
		.rx_len       (rx_len)
	);

	//////////////////////////////////////////////////////////////////////
	// Transmit encoder

	rgmii_tx_ddr i_rgmii_tx_ddr (
		.gmii_rxc     (gmii_rxc),
		.rst          (rst),
		.tx_data      (tx_data),
		.tx_en        (tx_en),
		.tx_er        (tx_er),
		.rgmii_txc    (rgmii_txc),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl)
	);

endmodule

// ==== testbench/rgmii_tb_model.svh ====
	typedef logic [7:0] byte_q_t [$];

	//////////////////////////////////////////////////////////////////////
	// Failure reporting

	task automatic stop_failed();
		$display("tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Typed compares

	task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic nibble_check(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic length_check(input string name, input logic [LEN_WIDTH-1:0] exp,
		input logic [LEN_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic flag_check(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
			stop_failed();
		end
	endtask

	task automatic speed_check(input string name, input gmii_speed_t exp, input gmii_speed_t act);
		if (act !== exp) begin
			$display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
			stop_failed();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// Frame on the wire plus error index, gives payload, length and error
	// Returns 0 when the framer has to drop the frame
	function automatic bit model_frame(input byte_q_t line_bytes, input int err_pos,
		output byte_q_t payload, output logic [LEN_WIDTH-1:0] len, output logic err);
		int i;
		int j;
		payload.delete();
		len = '0;
		err = 1'b0;
		if (line_bytes.size() == 0 || line_bytes[0] != PREAMBLE_BYTE || err_pos == 0)
			return 1'b0;
		i = 1;
		// Preamble runs until the delimiter
		while (i < line_bytes.size() && line_bytes[i] != SFD_BYTE) begin
			if (line_bytes[i] != PREAMBLE_BYTE || err_pos == i)
				return 1'b0;
			i++;
		end
		// No delimiter, or an error on it
		if (i >= line_bytes.size() || err_pos == i)
			return 1'b0;
		for (j = i + 1; j < line_bytes.size(); j++) begin
			if (payload.size() < MAX_LEN)
				payload.push_back(line_bytes[j]);
			if (err_pos == j)
				err = 1'b1;
		end
		// Overlong frame is cut with error
		if (line_bytes.size() - (i + 1) > MAX_LEN)
			err = 1'b1;
		if (payload.size() == 0)
			return 1'b0;
		len = LEN_WIDTH'(payload.size());
		return 1'b1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// RGMII driver

	// Low nibble with enable, then high nibble with enable xor error
	task automatic drive_byte(input logic [7:0] data, input logic en, input logic er);
		@(posedge gmii_rxc);
		#TB_DELAY;
		rgmii_rxd    = data[3:0];
		rgmii_rx_ctl = en;
		@(negedge gmii_rxc);
		#TB_DELAY;
		rgmii_rxd    = data[7:4];
		rgmii_rx_ctl = en ^ er;
		bytes_driven++;
	endtask

// ==== testbench/tb_rgmii_phy_if.sv ====
`timescale 1ns/1ps

module tb_rgmii_phy_if import rgmii_pkg::*; ();

	localparam int          LEN_WIDTH = 16;
	localparam logic [15:0] MAX_LEN   = 16'd64;
	localparam int          TB_DELAY  = 1;
	// Idle status bytes between frames
	localparam int          GAP_BYTES = 4;

	logic                 gmii_rxc;
	logic                 rst;
	logic [3:0]           rgmii_rxd;
	logic                 rgmii_rx_ctl;
	logic [7:0]           tx_data;
	logic                 tx_en;
	logic                 tx_er;
	logic                 rgmii_txc;
	logic [3:0]           rgmii_txd;
	logic                 rgmii_tx_ctl;
	logic [7:0]           rx_data;
	logic                 rx_valid;
	logic                 rx_sof;
	logic                 rx_eof;
	logic                 rx_err;
	logic [LEN_WIDTH-1:0] rx_len;
	logic                 link_up;
	gmii_speed_t          link_speed;
	logic                 full_duplex;

	int         seed = 32'hc730;
	int         bytes_driven = 0;
	int         cycles = 0;
	logic [7:0] cur_status = 8'h00;
	logic       tx_checks_on = 1'b0;

	// Expected frames, bytes flat with one length and error per frame
	logic [7:0]           exp_bytes[$];
	logic [LEN_WIDTH-1:0] exp_len[$];
	logic                 exp_err[$];
	logic [7:0]           got_q[$];
	logic [LEN_WIDTH-1:0] mon_len;
	logic                 mon_err;

	`include "rgmii_tb_model.svh"

	rgmii_phy_if #(
		.MAX_FRAME_LEN (MAX_LEN),
		.LEN_WIDTH     (LEN_WIDTH)
	) i_rgmii_phy_if (
		.gmii_rxc     (gmii_rxc),
		.rst          (rst),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.tx_data      (tx_data),
		.tx_en        (tx_en),
		.tx_er        (tx_er),
		.rgmii_txc    (rgmii_txc),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_sof       (rx_sof),
		.rx_eof       (rx_eof),
		.rx_err       (rx_err),
		.rx_len       (rx_len),
		.link_up      (link_up),
		.link_speed   (link_speed),
		.full_duplex  (full_duplex)
	);

	initial begin
		gmii_rxc = 1'b0;
		forever #5 gmii_rxc = ~gmii_rxc;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	task automatic build_frame(input int pre_cnt, input bit with_sfd, input int pay_len,
		output byte_q_t line_bytes);
		line_bytes.delete();
		repeat (pre_cnt) line_bytes.push_back(PREAMBLE_BYTE);
		if (with_sfd)
			line_bytes.push_back(SFD_BYTE);
		repeat (pay_len) line_bytes.push_back(8'($random(seed)));
	endtask

	task automatic status_matches();
		flag_check("link_up", cur_status[0], link_up);
		speed_check("link_speed", gmii_speed_t'(cur_status[2:1]), link_speed);
		flag_check("full_duplex", cur_status[3], full_duplex);
	endtask

	// Queue what the model expects, then put the frame and a gap on the pins
	task automatic send_frame(input byte_q_t line_bytes, input int err_pos);
		byte_q_t              payload;
		logic [LEN_WIDTH-1:0] len;
		logic                 err;
		if (model_frame(line_bytes, err_pos, payload, len, err)) begin
			foreach (payload[k])
				exp_bytes.push_back(payload[k]);
			exp_len.push_back(len);
			exp_err.push_back(err);
		end
		foreach (line_bytes[i])
			drive_byte(line_bytes[i], 1'b1, i == err_pos);
		// Frame bytes must leave the status alone before the gap refreshes it
		status_matches();
		repeat (GAP_BYTES) drive_byte(cur_status, 1'b0, 1'b0);
	endtask

	// Third byte returns just after the status edge, two cycles on
	task automatic set_status(input logic [7:0] st);
		cur_status = st;
		repeat (3) drive_byte(st, 1'b0, 1'b0);
		status_matches();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Receive tests

	task automatic run_rx_tests();
		byte_q_t line_bytes;
		int      n;
		set_status(8'h0D);
		// Good frames
		repeat (20) begin
			n = 1 + int'($unsigned($random(seed)) % 60);
			build_frame(7, 1'b1, n, line_bytes);
			send_frame(line_bytes, -1);
		end
		status_matches();
		// Error half-bit in the payload
		build_frame(7, 1'b1, 30, line_bytes);
		send_frame(line_bytes, 8 + int'($unsigned($random(seed)) % 30));
		// Error in the preamble
		build_frame(7, 1'b1, 20, line_bytes);
		send_frame(line_bytes, 3);
		// Wrong preamble byte
		build_frame(7, 1'b1, 20, line_bytes);
		line_bytes[2] = 8'h57;
		send_frame(line_bytes, -1);
		// No delimiter
		build_frame(7, 1'b0, 20, line_bytes);
		send_frame(line_bytes, -1);
		// Overlong, then a normal one
		build_frame(7, 1'b1, 100, line_bytes);
		send_frame(line_bytes, -1);
		build_frame(7, 1'b1, 12, line_bytes);
		send_frame(line_bytes, -1);
		// Carrier symbols in the gap leave the status alone
		repeat (3) drive_byte(~cur_status, 1'b0, 1'b1);
		status_matches();
		repeat (4) begin
			set_status(8'($random(seed)));
			build_frame(7, 1'b1, 1 + int'($unsigned($random(seed)) % 60), line_bytes);
			send_frame(line_bytes, -1);
			status_matches();
		end
	endtask

	task automatic run_tx_tests();
		repeat (300) begin
			@(posedge gmii_rxc);
			#TB_DELAY;
			tx_data = 8'($random(seed));
			tx_en   = 1'($random(seed));
			tx_er   = 1'($random(seed));
			bytes_driven++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst          = 1'b1;
		rgmii_rxd    = 4'h0;
		rgmii_rx_ctl = 1'b0;
		tx_data      = 8'h00;
		tx_en        = 1'b0;
		tx_er        = 1'b0;
		repeat (3) @(posedge gmii_rxc);
		#TB_DELAY;
		rst = 1'b0;
		@(negedge gmii_rxc);
		#TB_DELAY;
		flag_check("rx_valid", 1'b0, rx_valid);
		flag_check("rx_sof", 1'b0, rx_sof);
		flag_check("rx_eof", 1'b0, rx_eof);
		flag_check("rx_err", 1'b0, rx_err);
		flag_check("link_up", 1'b0, link_up);
		speed_check("link_speed", SPEED_10, link_speed);
		flag_check("full_duplex", 1'b0, full_duplex);
		flag_check("rgmii_tx_ctl", 1'b0, rgmii_tx_ctl);
		nibble_check("rgmii_txd", 4'h0, rgmii_txd);
		tx_checks_on = 1'b1;
		fork
			run_rx_tests();
			run_tx_tests();
		join
		// Every queued frame has to come out before the end
		while (exp_len.size() != 0)
			@(posedge gmii_rxc);
		// Room for a stray strobe after the last frame
		repeat (8) @(posedge gmii_rxc);
		if (got_q.size() != 0) begin
			fail_run("payload bytes came out with no end strobe");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Receive monitor

	// Outputs move on the rising edge, sampled on the falling one
	always @(negedge gmii_rxc) begin
		if (!rst) begin
			if (rx_valid) begin
				flag_check("rx_sof", got_q.size() == 0, rx_sof);
				got_q.push_back(rx_data);
			end else if (rx_sof) begin
				fail_run("start strobe came without a valid byte");
			end
			if (rx_eof) begin
				if (exp_len.size() == 0) begin
					fail_run("a frame came out when none was expected");
				end else begin
					mon_len = exp_len.pop_front();
					mon_err = exp_err.pop_front();
					length_check("rx_len", mon_len, rx_len);
					length_check("frame byte count", mon_len, LEN_WIDTH'(got_q.size()));
					flag_check("rx_err", mon_err, rx_err);
					foreach (got_q[i])
						compare_byte("rx_data", exp_bytes.pop_front(), got_q[i]);
					got_q.delete();
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transmit monitor

	// GMII inputs seen at the rising edge
	logic [7:0] tx_exp_data;
	logic       tx_exp_en;
	logic       tx_exp_er;

	always @(posedge gmii_rxc) begin
		if (rst) begin
			tx_exp_data <= 8'h00;
			tx_exp_en   <= 1'b0;
			tx_exp_er   <= 1'b0;
		end else begin
			tx_exp_data <= tx_data;
			tx_exp_en   <= tx_en;
			tx_exp_er   <= tx_er;
		end
	end

	always @(posedge gmii_rxc) begin
		#3;
		if (tx_checks_on) begin
			flag_check("rgmii_txc", 1'b1, rgmii_txc);
			nibble_check("rgmii_txd", tx_exp_data[3:0], rgmii_txd);
			flag_check("rgmii_tx_ctl", tx_exp_en, rgmii_tx_ctl);
		end
	end

	always @(negedge gmii_rxc) begin
		#3;
		if (tx_checks_on) begin
			flag_check("rgmii_txc", 1'b0, rgmii_txc);
			nibble_check("rgmii_txd", tx_exp_data[7:4], rgmii_txd);
			flag_check("rgmii_tx_ctl", tx_exp_en ^ tx_exp_er, rgmii_tx_ctl);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Timeout

	always @(posedge gmii_rxc) begin
		cycles++;
		if (cycles > 20 * bytes_driven + 500)
			fail_run("timeout, an expected frame or the stimulus never finished");
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
hdl/rgmii_pkg.sv
hdl/rgmii_rx_ddr.sv
hdl/rgmii_inband_status.sv
hdl/gmii_rx_framer.sv
hdl/rgmii_tx_ddr.sv
hdl/rgmii_phy_if.sv
testbench/tb_rgmii_phy_if.sv

// ==== Makefile ====
# Verilator build for the RGMII interface testbench

VERILATOR ?= verilator
TOP       ?= tb_rgmii_phy_if
OBJ_DIR   ?= obj_dir
FILE_LIST ?= vlog.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
